/* verilog/serial_rx_defs.svh */
`ifndef SERIAL_RX_DEFS_SVH
`define SERIAL_RX_DEFS_SVH

// register address width, enough for the three word offsets plus the unused 0xC slot
`define RX_ADDR_W 4

`define RX_REG_CTRL   4'h0 // enable and divider, read back as written
`define RX_REG_STATUS 4'h4 // fifo level, overrun and empty
`define RX_REG_DATA   4'h8 // pops one byte per read when the fifo holds data

// fifo geometry, the level needs one bit more than the pointers
`define RX_FIFO_DEPTH 16
`define RX_LVL_W      5

// smallest divider setting that keeps each sclk half-period at three clk cycles or more
`define RX_DIV_MIN 2

// axi4-lite response codes
`define RX_RESP_OKAY   2'b00
`define RX_RESP_SLVERR 2'b10

`endif

/* verilog/serial_rx_pkg.sv */
`include "serial_rx_defs.svh"

package serial_rx_pkg;

   // manager to subordinate side of the axi4-lite bus
   typedef struct packed {
      logic                  awvalid;
      logic [`RX_ADDR_W-1:0] awaddr;
      logic                  wvalid;
      logic [31:0]           wdata;
      logic [3:0]            wstrb;
      logic                  bready;
      logic                  arvalid;
      logic [`RX_ADDR_W-1:0] araddr;
      logic                  rready;
   } axil_req_t;

   // subordinate to manager side of the axi4-lite bus
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   // capture settings from the CTRL register
   typedef struct packed {
      logic       enable; // low holds sclk low and drops any partial byte
      logic [7:0] div;    // sclk half-period is div plus one clk cycles
   } rx_ctrl_t;

   // fifo state as seen by the register block
   typedef struct packed {
      logic [`RX_LVL_W-1:0] level;
      logic                 full;
      logic                 empty;
      logic                 overrun; // sticky until cleared through STATUS
   } rx_status_t;

endpackage

/* verilog/sclk_gen.sv */
module sclk_gen
   import serial_rx_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  rx_ctrl_t ctrl,
   output logic     sclk,
   output logic     sample
);

   logic [7:0] div_cnt; // clk cycles spent in the current sclk half-period
   logic       sclk_q;  // sclk one cycle back, used for the edge compare
   logic       wrap;    // end of a half-period

   // compare with >= so that shrinking div on the fly cannot strand the counter above it
   assign wrap = (div_cnt >= ctrl.div);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         div_cnt <= '0;
         sclk    <= 1'b0;
         sclk_q  <= 1'b0;
         sample  <= 1'b0;
      end else if (!ctrl.enable) begin
         div_cnt <= '0;   // restart cleanly on the next enable
         sclk    <= 1'b0; // serial clock parks low while disabled
         sclk_q  <= 1'b0;
         sample  <= 1'b0;
      end else begin
         if (wrap) begin
            div_cnt <= '0;
            sclk    <= ~sclk; // one half-period done
         end else begin
            div_cnt <= div_cnt + 8'd1;
         end
         sclk_q <= sclk;            // remember the previous level
         sample <= sclk & ~sclk_q;  // strobe lands in the cycle after sclk goes high
      end
   end

   // Since div is at least two, each half-period is three cycles or more, so the strobe
   // always falls well inside the high phase and the input bit has settled by then.

endmodule

/* verilog/spi_deserializer.sv */
module spi_deserializer
(
   input  logic       clk,
   input  logic       rst,
   input  logic       enable,
   input  logic       sample,
   input  logic       serial_in,
   output logic [7:0] byte_data,
   output logic       byte_valid
);

   logic [7:0] shift_reg; // bits collected so far, oldest bit highest
   logic [2:0] bit_cnt;   // number of bits already held, wraps after the eighth
   logic       last_bit;  // this strobe completes a byte

   assign last_bit = (bit_cnt == 3'd7);

   // the eighth bit goes straight into the output so the byte is ready on that strobe
   assign byte_data  = {shift_reg[6:0], serial_in};
   assign byte_valid = enable & sample & last_bit; // single cycle since sample is single cycle

   // bit counter is control state and gets cleared by reset and by disable
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bit_cnt <= '0;
      end else if (!enable) begin
         bit_cnt <= '0; // partial byte is thrown away
      end else if (sample) begin
         bit_cnt <= bit_cnt + 3'd1; // wraps to zero after the eighth bit
      end
   end

   // msb arrives first, so shifting in at the low end leaves it at bit 7
   always_ff @(posedge clk) begin
      if (enable && sample) begin
         shift_reg <= {shift_reg[6:0], serial_in};
      end
   end

   // Stale bits left in shift_reg after a disable are harmless. The counter restarts at
   // zero, and eight fresh shifts push every old bit out before the next byte is handed
   // over.

endmodule

/* verilog/rx_fifo.sv */
`include "serial_rx_defs.svh"

module rx_fifo
   import serial_rx_pkg::*;
#(
   parameter int DEPTH = 16
)
(
   input  logic       clk,
   input  logic       rst,
   input  logic       push,
   input  logic [7:0] push_data,
   input  logic       pop,
   output logic [7:0] pop_data,
   input  logic       overrun_clr,
   output rx_status_t status
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [7:0]       mem [DEPTH]; // byte storage, no reset needed
   logic [PTR_W-1:0] wr_ptr;      // next slot to write, wraps on its own for a power of two
   logic [PTR_W-1:0] rd_ptr;      // head of the queue
   logic [PTR_W:0]   count;       // bytes currently held, 0 to DEPTH
   logic             full;
   logic             empty;
   logic             overrun;     // a byte was lost since the last clear
   logic             do_push;     // push that actually stores
   logic             do_pop;      // pop that actually removes

   assign full    = (count == DEPTH[PTR_W:0]);
   assign empty   = (count == '0);
   assign do_push = push & ~full;  // a push into a full fifo is dropped
   assign do_pop  = pop & ~empty;  // a pop from an empty fifo is ignored

   assign pop_data = mem[rd_ptr];  // head entry is always on show

   assign status.level   = `RX_LVL_W'(count);
   assign status.full    = full;
   assign status.empty   = empty;
   assign status.overrun = overrun;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         overrun <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither keep the level
         endcase
         // a drop in the same cycle as a clear wins, so no loss goes unreported
         if (push && full)     overrun <= 1'b1;
         else if (overrun_clr) overrun <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
   end

endmodule

/* verilog/rx_regs.sv */
`include "serial_rx_defs.svh"

module rx_regs
   import serial_rx_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  axil_req_t  axil_req,
   output axil_rsp_t  axil_rsp,
   output rx_ctrl_t   ctrl,
   input  rx_status_t status,
   input  logic [7:0] pop_data,
   output logic       pop,
   output logic       overrun_clr
);

   logic        wr_ready; // awready and wready, one pulse per accepted write
   logic        wr_fire;  // write handshake on this edge
   logic        bvalid;
   logic [1:0]  bresp;
   logic        rd_ready; // arready pulse
   logic        rd_fire;  // read address handshake on this edge
   logic        rvalid;
   logic [1:0]  rresp;
   logic [31:0] rdata;    // held stable while rvalid waits on rready
   logic [31:0] rd_word;  // read value chosen by address in the accept cycle
   logic        rd_ok;    // read address decodes to a register
   logic        wr_ok;    // write address decodes to a register

   // both write channels must be offered before the pair is taken
   assign wr_fire = wr_ready & axil_req.awvalid & axil_req.wvalid;
   assign rd_fire = rd_ready & axil_req.arvalid;

   // DATA is read-only but sits in the map, so a write to it is accepted and ignored
   assign wr_ok = (axil_req.awaddr == `RX_REG_CTRL) ||
                  (axil_req.awaddr == `RX_REG_STATUS) ||
                  (axil_req.awaddr == `RX_REG_DATA);
   assign rd_ok = (axil_req.araddr == `RX_REG_CTRL) ||
                  (axil_req.araddr == `RX_REG_STATUS) ||
                  (axil_req.araddr == `RX_REG_DATA);

   // write-1-to-clear of overrun at STATUS bit 8, which lives in byte lane 1
   assign overrun_clr = wr_fire && (axil_req.awaddr == `RX_REG_STATUS) &&
                        axil_req.wstrb[1] && axil_req.wdata[8];

   // pop only when a DATA read is taken and there is something to hand out
   assign pop = rd_fire && (axil_req.araddr == `RX_REG_DATA) && !status.empty;

   // read mux, sampled into rdata on the accept edge
   always_comb begin
      rd_word = '0;
      case (axil_req.araddr)
         `RX_REG_CTRL: begin
            rd_word[0]    = ctrl.enable;
            rd_word[15:8] = ctrl.div;
         end
         `RX_REG_STATUS: begin
            rd_word[`RX_LVL_W-1:0] = status.level;
            rd_word[8]             = status.overrun;
            rd_word[9]             = status.empty;
         end
         `RX_REG_DATA: begin
            if (!status.empty) begin
               rd_word[7:0] = pop_data; // head byte, leaves the fifo on this edge
               rd_word[31]  = 1'b1;     // tells software the byte is real
            end
         end
         default: rd_word = '0; // unmapped, answered with SLVERR
      endcase
   end

   // write channel with at most one write outstanding
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ready <= 1'b0;
         bvalid   <= 1'b0;
         bresp    <= `RX_RESP_OKAY;
         ctrl     <= '0;
      end else begin
         // ready pulses one cycle after both valids, never while a response waits
         wr_ready <= !wr_ready && !bvalid && axil_req.awvalid && axil_req.wvalid;
         if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? `RX_RESP_OKAY : `RX_RESP_SLVERR;
            if (axil_req.awaddr == `RX_REG_CTRL) begin
               if (axil_req.wstrb[0]) ctrl.enable <= axil_req.wdata[0];
               if (axil_req.wstrb[1]) ctrl.div    <= axil_req.wdata[15:8];
            end
         end else if (bvalid && axil_req.bready) begin
            bvalid <= 1'b0; // response taken, next write may start
         end
      end
   end

   // read channel with at most one read outstanding
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ready <= 1'b0;
         rvalid   <= 1'b0;
         rresp    <= `RX_RESP_OKAY;
      end else begin
         rd_ready <= !rd_ready && !rvalid && axil_req.arvalid; // no accept while rvalid waits
         if (rd_fire) begin
            rvalid <= 1'b1;
            rresp  <= rd_ok ? `RX_RESP_OKAY : `RX_RESP_SLVERR;
         end else if (rvalid && axil_req.rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // read data is payload and only changes on an accept
   always_ff @(posedge clk) begin
      if (rd_fire) rdata <= rd_word;
   end

   always_comb begin
      axil_rsp         = '0;
      axil_rsp.awready = wr_ready; // address and data ready move together
      axil_rsp.wready  = wr_ready;
      axil_rsp.bvalid  = bvalid;
      axil_rsp.bresp   = bresp;
      axil_rsp.arready = rd_ready;
      axil_rsp.rvalid  = rvalid;
      axil_rsp.rdata   = rdata;
      axil_rsp.rresp   = rresp;
   end

endmodule

/* verilog/serial_rx_top.sv */
`include "serial_rx_defs.svh"

module serial_rx_top
   import serial_rx_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  axil_req_t axil_req,
   output axil_rsp_t axil_rsp,
   output logic      sclk,
   input  logic      serial_in
);

   rx_ctrl_t   ctrl;        // enable and divider from CTRL
   rx_status_t status;      // fifo level and flags back to STATUS
   logic       sample;      // one pulse per sclk rising edge
   logic [7:0] byte_data;   // finished byte from the deserializer
   logic       byte_valid;  // pushes byte_data into the fifo
   logic [7:0] pop_data;    // fifo head for DATA reads
   logic       pop;         // DATA read accepted on a non-empty fifo
   logic       overrun_clr; // write-1 to STATUS bit 8

   // register block, the only part that talks to the bus
   rx_regs u_regs (
      .clk         (clk),
      .rst         (rst),
      .axil_req    (axil_req),
      .axil_rsp    (axil_rsp),
      .ctrl        (ctrl),
      .status      (status),
      .pop_data    (pop_data),
      .pop         (pop),
      .overrun_clr (overrun_clr)
   );

   // serial clock for the microcontroller and the matching sample strobe
   sclk_gen u_sclk_gen (
      .clk    (clk),
      .rst    (rst),
      .ctrl   (ctrl),
      .sclk   (sclk),
      .sample (sample)
   );

   // only the enable bit matters here, it drops a partial byte when cleared
   spi_deserializer u_deser (
      .clk        (clk),
      .rst        (rst),
      .enable     (ctrl.enable),
      .sample     (sample),
      .serial_in  (serial_in),
      .byte_data  (byte_data),
      .byte_valid (byte_valid)
   );

   // byte buffer between capture and software, drops on full and flags it
   rx_fifo #(
      .DEPTH (`RX_FIFO_DEPTH)
   ) u_fifo (
      .clk         (clk),
      .rst         (rst),
      .push        (byte_valid),
      .push_data   (byte_data),
      .pop         (pop),
      .pop_data    (pop_data),
      .overrun_clr (overrun_clr),
      .status      (status)
   );

endmodule

/* verif/tb_clk_gen.sv */
module tb_clk_gen
(
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // period of 10 time units
   end

   initial begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0; // released on an edge so every process sees the same cycle
   end

endmodule

/* verif/serial_rx_chk.sv */
`include "serial_rx_defs.svh"

module serial_rx_chk
   import serial_rx_pkg::*;
(
   input logic                 clk,
   input logic                 rst,
   input axil_req_t            axil_req,
   input axil_rsp_t            axil_rsp,
   input logic                 sclk,
   input logic                 enable,
   input logic [`RX_LVL_W-1:0] level
);

   int fail_cnt = 0; // assertion failures seen so far

   // a read response keeps its data until the manager takes it
   rdata_hold: assert property (@(posedge clk) disable iff (rst)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
      else begin
         $error("read response dropped or changed before rready");
         fail_cnt++;
      end

   // write response waits for bready
   bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else begin
         $error("write response dropped before bready");
         fail_cnt++;
      end

   // sclk is registered, so it parks low one cycle after enable falls
   sclk_idle: assert property (@(posedge clk) disable iff (rst) !enable |=> !sclk)
      else begin
         $error("sclk active while capture is disabled");
         fail_cnt++;
      end

   level_bound: assert property (@(posedge clk) disable iff (rst) level <= `RX_FIFO_DEPTH)
      else begin
         $error("fifo level above its depth");
         fail_cnt++;
      end

endmodule

bind serial_rx_top serial_rx_chk u_chk (
   .clk      (clk),
   .rst      (rst),
   .axil_req (axil_req),
   .axil_rsp (axil_rsp),
   .sclk     (sclk),
   .enable   (ctrl.enable),
   .level    (status.level)
);

/* verif/serial_rx_tb.sv */
`include "serial_rx_defs.svh"

module serial_rx_tb
   import serial_rx_pkg::*;
();

   // about 40 bytes at up to 160 cycles each, plus register traffic, then tripled for margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        rst;
   axil_req_t   req;
   axil_rsp_t   rsp;
   logic        sclk;
   logic        serial_in = 1'b0; // idle level until the first bit is loaded
   logic [31:0] lcg_state = 32'h7358_5d50;
   logic        bits_q[$];        // serial bits still to go out with the head on serial_in
   int          fall_cnt = 0;     // sclk falling edges seen so far
   logic        sclk_prev = 1'b0; // sclk one cycle back
   logic [7:0]  model_q[$];       // bytes the fifo should hold with the oldest first
   logic        exp_ovr;          // overrun flag the model expects
   logic [31:0] ctrl_word;        // last value written to CTRL
   int          cycle_cnt = 0;
   string       test_name;
   logic [1:0]  resp;
   logic [31:0] rdata;

   tb_clk_gen u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   serial_rx_top u_dut (
      .clk       (clk),
      .rst       (rst),
      .axil_req  (req),
      .axil_rsp  (rsp),
      .sclk      (sclk),
      .serial_in (serial_in)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = lcg_next();
      return r[31:24]; // upper bits of an lcg are the most random
   endfunction

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("test %s timed out after %0d cycles", test_name, cycle_cnt);
         $display("TEST RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   // the bound checker counts its assertion failures
   always @(posedge clk) begin
      if (u_dut.u_chk.fail_cnt != 0) begin
         $display("test %s hit a failing bus or fifo assertion", test_name);
         $display("TEST RESULT: FAIL");
         $fatal(1, "assertion failure");
      end
   end

   // the microcontroller moves to the next bit on the clk edge after sclk falls
   always @(posedge clk) begin
      sclk_prev <= sclk;
      if (sclk_prev && !sclk) begin
         fall_cnt <= fall_cnt + 1;
         if (bits_q.size() > 0) bits_q.delete(0); // that bit was sampled in the high phase
      end
      if (bits_q.size() > 0) serial_in <= bits_q[0];
   end

   task automatic check_value(input string label, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h", test_name, label, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] bresp);
      int gap;
      gap = int'(rand_byte() % 4); // random bready back-pressure
      req.awvalid <= 1'b1;
      req.awaddr  <= addr;
      req.wvalid  <= 1'b1;
      req.wdata   <= data;
      req.wstrb   <= 4'hf;
      @(posedge clk);
      while (!(rsp.awready && rsp.wready)) @(posedge clk);
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
      repeat (gap) @(posedge clk);
      req.bready <= 1'b1;
      @(posedge clk);
      while (!rsp.bvalid) @(posedge clk);
      bresp = rsp.bresp;
      req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] rresp);
      int gap;
      gap = int'(rand_byte() % 4); // random rready back-pressure
      req.arvalid <= 1'b1;
      req.araddr  <= addr;
      @(posedge clk);
      while (!rsp.arready) @(posedge clk);
      req.arvalid <= 1'b0;
      repeat (gap) @(posedge clk);
      req.rready <= 1'b1;
      @(posedge clk);
      while (!rsp.rvalid) @(posedge clk);
      data  = rsp.rdata;
      rresp = rsp.rresp;
      req.rready <= 1'b0;
   endtask

   task automatic expect_read(input logic [3:0] addr, input logic [31:0] exp,
                              input logic [1:0] exp_resp, input string label);
      axil_read(addr, rdata, resp);
      check_value({label, " data"}, exp, rdata);
      check_value({label, " resp"}, {30'd0, exp_resp}, {30'd0, resp});
   endtask

   // STATUS as the model sees it with level in 4:0 and overrun and empty in bits 8 and 9
   function automatic logic [31:0] status_word();
      int lvl;
      lvl = model_q.size();
      return {22'd0, lvl == 0, exp_ovr, 3'd0, lvl[4:0]};
   endfunction

   // the model keeps only what fits and a dropped byte means overrun
   task automatic queue_byte(input logic [7:0] b);
      for (int i = 7; i >= 0; i--) bits_q.push_back(b[i]);
      if (model_q.size() < `RX_FIFO_DEPTH) model_q.push_back(b);
      else exp_ovr = 1'b1;
   endtask

   // sends every queued bit with capture enabled, then disables
   task automatic run_capture(input logic [7:0] div);
      int nbits;
      int start;
      nbits = bits_q.size();
      start = fall_cnt;
      ctrl_word = {16'd0, div, 8'h01};
      axil_write(`RX_REG_CTRL, ctrl_word, resp);
      check_value("enable resp", {30'd0, `RX_RESP_OKAY}, {30'd0, resp});
      expect_read(`RX_REG_CTRL, ctrl_word, `RX_RESP_OKAY, "ctrl readback");
      while (fall_cnt < start + nbits) @(posedge clk); // fall n means bit n was sampled
      ctrl_word = {16'd0, div, 8'h00};
      axil_write(`RX_REG_CTRL, ctrl_word, resp);
      check_value("disable resp", {30'd0, `RX_RESP_OKAY}, {30'd0, resp});
      repeat (3) @(posedge clk); // sclk parks low before the next stream is loaded
   endtask

   task automatic drain_fifo();
      while (model_q.size() > 0)
         expect_read(`RX_REG_DATA, {1'b1, 23'd0, model_q.pop_front()}, `RX_RESP_OKAY, "pop");
      expect_read(`RX_REG_STATUS, status_word(), `RX_RESP_OKAY, "status after drain");
   endtask

   initial begin
      logic [7:0] div;
      logic [7:0] b;
      req       = '0;
      exp_ovr   = 1'b0;
      test_name = "reset";
      @(posedge clk);
      while (rst) @(posedge clk);

      expect_read(`RX_REG_CTRL, 32'd0, `RX_RESP_OKAY, "ctrl");
      expect_read(`RX_REG_STATUS, status_word(), `RX_RESP_OKAY, "status");
      expect_read(`RX_REG_DATA, 32'd0, `RX_RESP_OKAY, "data");
      repeat (20) begin
         @(posedge clk);
         check_value("sclk idle", 32'd0, {31'd0, sclk});
      end

      test_name = "streaming";
      repeat (3) begin
         div = 8'(`RX_DIV_MIN + rand_byte() % (10 - `RX_DIV_MIN));
         repeat (8) queue_byte(rand_byte());
         run_capture(div);
         drain_fifo();
      end

      test_name = "overrun";
      repeat (`RX_FIFO_DEPTH + 2) queue_byte(rand_byte());
      run_capture(8'(`RX_DIV_MIN));
      expect_read(`RX_REG_STATUS, status_word(), `RX_RESP_OKAY, "status full");
      axil_write(`RX_REG_STATUS, 32'h0000_0000, resp);
      check_value("status write resp", {30'd0, `RX_RESP_OKAY}, {30'd0, resp});
      expect_read(`RX_REG_STATUS, status_word(), `RX_RESP_OKAY, "overrun kept");
      axil_write(`RX_REG_STATUS, 32'h0000_0100, resp);
      check_value("status clear resp", {30'd0, `RX_RESP_OKAY}, {30'd0, resp});
      exp_ovr = 1'b0;
      expect_read(`RX_REG_STATUS, status_word(), `RX_RESP_OKAY, "overrun cleared");
      drain_fifo();

      test_name = "partial byte";
      b = rand_byte();
      for (int i = 7; i >= 4; i--) bits_q.push_back(b[i]); // half a byte ahead of the disable
      run_capture(8'd3);
      queue_byte(rand_byte());
      run_capture(8'd3);
      drain_fifo();

      test_name = "bad access";
      expect_read(`RX_REG_DATA, 32'd0, `RX_RESP_OKAY, "empty data");
      axil_read(4'hc, rdata, resp);
      check_value("unmapped read resp", {30'd0, `RX_RESP_SLVERR}, {30'd0, resp});
      axil_write(4'hc, 32'hffff_ffff, resp);
      check_value("unmapped write resp", {30'd0, `RX_RESP_SLVERR}, {30'd0, resp});
      expect_read(`RX_REG_CTRL, ctrl_word, `RX_RESP_OKAY, "ctrl unchanged");

      if (u_dut.u_chk.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+verilog
verilog/serial_rx_pkg.sv
verilog/sclk_gen.sv
verilog/spi_deserializer.sv
verilog/rx_fifo.sv
verilog/rx_regs.sv
verilog/serial_rx_top.sv
verif/tb_clk_gen.sv
verif/serial_rx_chk.sv
verif/serial_rx_tb.sv
